/* build.f */
logic/mem_issue_pkg.sv
logic/mem_rs.sv
logic/issue_arbiter.sv
logic/agu.sv
logic/mem_issue_top.sv
verification/mem_issue_props.sv
verification/mem_issue_tb.sv

/* logic/agu.sv */
////////////////////////////////////////////////////////////
// address unit, one registered request per grant
// no back-pressure, mem_valid is a single cycle pulse
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module agu import mem_issue_pkg::*; (
    input  wire logic            clock,
    input  wire logic            rst,
    input  wire logic            flush,
    input  wire logic            load_grant,
    input  wire logic            store_grant,
    input  wire operand_t        load_base,
    input  wire logic [xlen-1:0] load_offset,
    input  wire load_info_t      load_payload,
    input  wire operand_t        store_base,
    input  wire operand_t        store_src,
    input  wire logic [xlen-1:0] store_offset,
    input  wire store_info_t     store_payload,
    output logic                 mem_valid,
    output mem_req_t             mem_req
);

    logic [xlen-1:0] base_sel;
    logic [xlen-1:0] offset_sel;
    mem_req_t        req_next;

    assign base_sel   = store_grant ? store_base.value : load_base.value;
    assign offset_sel = store_grant ? store_offset : load_offset;

    always_comb begin
        req_next      = '0;
        req_next.addr = base_sel + offset_sel;   // single shared adder
        if (store_grant) begin
            req_next.is_store = 1'b1;
            req_next.data     = store_src.value;
            req_next.mem_size = store_payload.mem_size;
            req_next.rob_idx  = store_payload.rob_idx;
            req_next.lsq_idx  = store_payload.sq_idx;
        end else begin
            req_next.mem_size  = load_payload.mem_size;
            req_next.rob_idx   = load_payload.rob_idx;
            req_next.lsq_idx   = load_payload.lq_idx;
            req_next.dest_preg = load_payload.dest_preg;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || flush) mem_valid <= 1'b0;
        else              mem_valid <= load_grant || store_grant;
    end

    always_ff @(posedge clock) begin
        if (load_grant || store_grant) mem_req <= req_next;
    end

endmodule

`default_nettype wire

/* logic/issue_arbiter.sv */
////////////////////////////////////////////////////////////
// two-way round-robin grant for the single address unit
// load side wins the first tie after reset or flush
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module issue_arbiter (
    input  wire logic clock,
    input  wire logic rst,
    input  wire logic flush,
    input  wire logic load_request,
    input  wire logic store_request,
    output logic      load_grant,
    output logic      store_grant
);

    logic last_load;   // last winner was the load station
    logic load_first;

    assign load_first  = !last_load;

    // no grant while the stations are being emptied
    assign load_grant  = !flush && load_request && (!store_request || load_first);
    assign store_grant = !flush && store_request && (!load_request || !load_first);

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            last_load <= 1'b0;
        end else if (load_grant) begin
            last_load <= 1'b1;
        end else if (store_grant) begin
            last_load <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/mem_issue_pkg.sv */
////////////////////////////////////////////////////////////
// shared widths and packed types for the memory issue stage
// a not-ready operand carries its physical tag in the low value bits
////////////////////////////////////////////////////////////
`default_nettype none

package mem_issue_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int xlen     = 32;
    localparam int preg_len = 6;   // physical register tag
    localparam int rob_len  = 5;
    localparam int lsq_len  = 4;   // load or store queue index

    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_e;

    ////////////////////////////////////////////////////////////
    // packed structs
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic            ready;
        logic [xlen-1:0] value;    // tag in low bits until ready
    } operand_t;

    typedef struct packed {
        mem_size_e           mem_size;
        logic [rob_len-1:0]  rob_idx;
        logic [lsq_len-1:0]  lq_idx;
        logic [preg_len-1:0] dest_preg;
    } load_info_t;

    typedef struct packed {
        mem_size_e          mem_size;
        logic [rob_len-1:0] rob_idx;
        logic [lsq_len-1:0] sq_idx;
    } store_info_t;

    typedef struct packed {
        logic                valid;
        logic [preg_len-1:0] tag;
        logic [xlen-1:0]     value;
    } cdb_t;

    typedef struct packed {
        logic                is_store;
        logic [xlen-1:0]     addr;
        logic [xlen-1:0]     data;       // store data, zero for loads
        mem_size_e           mem_size;
        logic [rob_len-1:0]  rob_idx;
        logic [lsq_len-1:0]  lsq_idx;    // lq_idx or sq_idx
        logic [preg_len-1:0] dest_preg;  // zero for stores
    } mem_req_t;

endpackage

`default_nettype wire

/* logic/mem_issue_top.sv */
////////////////////////////////////////////////////////////
// memory issue stage, two stations sharing one address unit
// dispatcher must hold off a strobe while that station is full
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mem_issue_top import mem_issue_pkg::*; #(
    parameter int rs_entries = 8
) (
    input  wire logic            clock,
    input  wire logic            rst,
    input  wire logic            flush,
    input  wire logic            load_enable,
    input  wire operand_t        load_base,
    input  wire logic [xlen-1:0] load_offset,
    input  wire load_info_t      load_info,
    input  wire logic            store_enable,
    input  wire operand_t        store_base,
    input  wire operand_t        store_src,
    input  wire logic [xlen-1:0] store_offset,
    input  wire store_info_t     store_info,
    input  wire cdb_t            cdb,
    output logic                 load_full,
    output logic                 store_full,
    output logic                 mem_valid,
    output mem_req_t             mem_req
);

    ////////////////////////////////////////////////////////////
    // station outputs
    ////////////////////////////////////////////////////////////
    operand_t        load_src_tied;   // loads have no data operand
    logic            load_request;
    logic            load_grant;
    operand_t        load_issue_base;
    logic [xlen-1:0] load_issue_offset;
    load_info_t      load_issue_payload;

    logic            store_request;
    logic            store_grant;
    operand_t        store_issue_base;
    operand_t        store_issue_src;
    logic [xlen-1:0] store_issue_offset;
    store_info_t     store_issue_payload;

    assign load_src_tied = '{ready: 1'b1, value: '0};

    mem_rs #(
        .rs_entries (rs_entries),
        .payload_t  (load_info_t)
    ) load_rs (
        .clock         (clock),
        .rst           (rst),
        .flush         (flush),
        .enable        (load_enable),
        .base_in       (load_base),
        .src_in        (load_src_tied),
        .offset_in     (load_offset),
        .payload_in    (load_info),
        .cdb           (cdb),
        .grant         (load_grant),
        .request       (load_request),
        .issue_base    (load_issue_base),
        .issue_src     (),
        .issue_offset  (load_issue_offset),
        .issue_payload (load_issue_payload),
        .full          (load_full)
    );

    mem_rs #(
        .rs_entries (rs_entries),
        .payload_t  (store_info_t)
    ) store_rs (
        .clock         (clock),
        .rst           (rst),
        .flush         (flush),
        .enable        (store_enable),
        .base_in       (store_base),
        .src_in        (store_src),
        .offset_in     (store_offset),
        .payload_in    (store_info),
        .cdb           (cdb),
        .grant         (store_grant),
        .request       (store_request),
        .issue_base    (store_issue_base),
        .issue_src     (store_issue_src),
        .issue_offset  (store_issue_offset),
        .issue_payload (store_issue_payload),
        .full          (store_full)
    );

    ////////////////////////////////////////////////////////////
    // shared address unit
    ////////////////////////////////////////////////////////////
    issue_arbiter arb (
        .clock         (clock),
        .rst           (rst),
        .flush         (flush),
        .load_request  (load_request),
        .store_request (store_request),
        .load_grant    (load_grant),
        .store_grant   (store_grant)
    );

    agu addr_unit (
        .clock         (clock),
        .rst           (rst),
        .flush         (flush),
        .load_grant    (load_grant),
        .store_grant   (store_grant),
        .load_base     (load_issue_base),
        .load_offset   (load_issue_offset),
        .load_payload  (load_issue_payload),
        .store_base    (store_issue_base),
        .store_src     (store_issue_src),
        .store_offset  (store_issue_offset),
        .store_payload (store_issue_payload),
        .mem_valid     (mem_valid),
        .mem_req       (mem_req)
    );

endmodule

`default_nettype wire

/* logic/mem_rs.sv */
////////////////////////////////////////////////////////////
// generic memory reservation station, lowest free slot on dispatch
// a cdb broadcast in the dispatch cycle does not reach the new entry
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mem_rs import mem_issue_pkg::*; #(
    parameter int  rs_entries = 8,
    parameter type payload_t  = load_info_t
) (
    input  wire logic            clock,
    input  wire logic            rst,
    input  wire logic            flush,
    input  wire logic            enable,
    input  wire operand_t        base_in,
    input  wire operand_t        src_in,
    input  wire logic [xlen-1:0] offset_in,
    input  wire payload_t        payload_in,
    input  wire cdb_t            cdb,
    input  wire logic            grant,
    output logic                 request,
    output operand_t             issue_base,
    output operand_t             issue_src,
    output logic [xlen-1:0]      issue_offset,
    output payload_t             issue_payload,
    output logic                 full
);

    localparam int idx_len = (rs_entries > 1) ? $clog2(rs_entries) : 1;
    localparam int cnt_len = $clog2(rs_entries + 1);

    typedef struct packed {
        operand_t        base;
        operand_t        src;
        logic [xlen-1:0] offset;
        payload_t        payload;
    } entry_t;

    entry_t [rs_entries-1:0] entries;
    logic   [rs_entries-1:0] free_q;
    logic   [cnt_len-1:0]    count_q;

    logic   [rs_entries-1:0] ready_vec;
    logic   [idx_len-1:0]    free_idx;
    logic   [idx_len-1:0]    issue_idx;
    logic                    issue;

    ////////////////////////////////////////////////////////////
    // slot selection
    ////////////////////////////////////////////////////////////
    always_comb begin
        free_idx = '0;
        for (int i = rs_entries - 1; i >= 0; i--) begin
            if (free_q[i]) free_idx = idx_len'(i);   // ends on the lowest free
        end
    end

    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            ready_vec[i] = !free_q[i] && entries[i].base.ready && entries[i].src.ready;
        end
    end

    always_comb begin
        issue_idx = '0;
        for (int i = rs_entries - 1; i >= 0; i--) begin
            if (ready_vec[i]) issue_idx = idx_len'(i);
        end
    end

    assign request       = |ready_vec;
    assign issue         = grant && request;
    assign full          = (count_q == cnt_len'(rs_entries));
    assign issue_base    = entries[issue_idx].base;
    assign issue_src     = entries[issue_idx].src;
    assign issue_offset  = entries[issue_idx].offset;
    assign issue_payload = entries[issue_idx].payload;

    ////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            free_q  <= '1;
            count_q <= '0;
        end else begin
            count_q <= count_q + cnt_len'(enable) - cnt_len'(issue);
            if (enable) free_q[free_idx] <= 1'b0;
            if (issue) free_q[issue_idx] <= 1'b1;   // never the slot being filled
        end
    end

    // entry contents, dispatch and cdb wakeup
    always_ff @(posedge clock) begin
        if (enable) begin
            entries[free_idx].base    <= base_in;
            entries[free_idx].src     <= src_in;
            entries[free_idx].offset  <= offset_in;
            entries[free_idx].payload <= payload_in;
        end
        if (cdb.valid) begin
            for (int i = 0; i < rs_entries; i++) begin
                if (!free_q[i]) begin
                    if (!entries[i].base.ready &&
                        entries[i].base.value[preg_len-1:0] == cdb.tag) begin
                        entries[i].base <= '{ready: 1'b1, value: cdb.value};
                    end
                    if (!entries[i].src.ready &&
                        entries[i].src.value[preg_len-1:0] == cdb.tag) begin
                        entries[i].src <= '{ready: 1'b1, value: cdb.value};
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the memory issue testbench with verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module mem_issue_tb -o mem_issue_sim &&
./obj_dir/mem_issue_sim || exit 1

/* verification/mem_issue_props.sv */
////////////////////////////////////////////////////////////
// bound to mem_issue_top, grant and output rules at each clock edge
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mem_issue_props (
    input wire logic clock,
    input wire logic rst,
    input wire logic flush,
    input wire logic load_enable,
    input wire logic store_enable,
    input wire logic load_full,
    input wire logic store_full,
    input wire logic load_grant,
    input wire logic store_grant,
    input wire logic mem_valid
);

    one_grant: assert property (@(posedge clock) disable iff (rst)
        !(load_grant && store_grant))
        else $error("load and store stations granted in the same cycle");

    quiet_after_clear: assert property (@(posedge clock) (rst || flush) |=> !mem_valid)
        else $error("mem_valid high in the cycle after reset or flush");

    no_dispatch_when_full: assert property (@(posedge clock) disable iff (rst)
        !(load_enable && load_full) && !(store_enable && store_full))
        else $error("dispatch strobe while the station is full");

    valid_after_grant: assert property (@(posedge clock) disable iff (rst)
        (load_grant || store_grant) |=> mem_valid)
        else $error("grant not followed by mem_valid");

    valid_needs_grant: assert property (@(posedge clock) disable iff (rst)
        mem_valid |-> $past(load_grant || store_grant))
        else $error("mem_valid without a grant one cycle before");

endmodule

`default_nettype wire

/* verification/mem_issue_tb.sv */
////////////////////////////////////////////////////////////
// random load and store traffic checked by a scoreboard on rob_idx
// inputs change and outputs are sampled on the falling edge
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mem_issue_tb import mem_issue_pkg::*; ();

    localparam int rs_entries   = 8;
    localparam int stim_cycles  = 3000;
    localparam int drain_margin = 1000;
    localparam int cycle_limit  = stim_cycles + drain_margin;   // 4000
    localparam int rob_slots    = 1 << rob_len;
    localparam int tag_count    = 1 << preg_len;

    typedef struct packed {
        logic                valid;
        logic                is_store;
        operand_t            base;
        operand_t            src;
        logic [xlen-1:0]     offset;
        mem_size_e           mem_size;
        logic [lsq_len-1:0]  lsq_idx;
        logic [preg_len-1:0] dest_preg;
    } expect_t;

    logic                 clock = 1'b0;
    logic                 rst;
    logic                 flush;
    logic                 load_enable;
    operand_t             load_base;
    logic [xlen-1:0]      load_offset;
    load_info_t           load_info;
    logic                 store_enable;
    operand_t             store_base;
    operand_t             store_src;
    logic [xlen-1:0]      store_offset;
    store_info_t          store_info;
    cdb_t                 cdb;
    logic                 load_full;
    logic                 store_full;
    logic                 mem_valid;
    mem_req_t             mem_req;

    expect_t              sb [rob_slots];   // expected requests by rob_idx
    logic [tag_count-1:0] tag_waiting;      // tags handed out, not yet broadcast
    int                   load_count;       // model occupancy
    int                   store_count;
    int                   cycle;
    int                   quiet_cycles;
    string                test_name;
    logic [15:0]          lfsr_state;

    mem_issue_top #(.rs_entries(rs_entries)) dut (
        .clock        (clock),
        .rst          (rst),
        .flush        (flush),
        .load_enable  (load_enable),
        .load_base    (load_base),
        .load_offset  (load_offset),
        .load_info    (load_info),
        .store_enable (store_enable),
        .store_base   (store_base),
        .store_src    (store_src),
        .store_offset (store_offset),
        .store_info   (store_info),
        .cdb          (cdb),
        .load_full    (load_full),
        .store_full   (store_full),
        .mem_valid    (mem_valid),
        .mem_req      (mem_req)
    );

    bind mem_issue_top mem_issue_props props (
        .clock        (clock),
        .rst          (rst),
        .flush        (flush),
        .load_enable  (load_enable),
        .store_enable (store_enable),
        .load_full    (load_full),
        .store_full   (store_full),
        .load_grant   (load_grant),
        .store_grant  (store_grant),
        .mem_valid    (mem_valid)
    );

    always begin
        #10 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // random source and model helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);   // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic mem_size_e random_size();
        return mem_size_e'(2'(rand_bits(2) % 3));
    endfunction

    // a quarter of the operands wait on a tag, all of them while filling
    function automatic operand_t make_operand(logic force_wait);
        operand_t            op;
        logic [preg_len-1:0] t;
        if (force_wait || rand_bits(2) == 0) begin
            t = preg_len'(rand_bits(preg_len));
            if (cdb.valid && cdb.tag == t) begin
                op = '{ready: 1'b1, value: cdb.value};   // value is on the bus now
            end else begin
                op = '{ready: 1'b0, value: xlen'(t)};
                tag_waiting[t] = 1'b1;
            end
        end else begin
            op = '{ready: 1'b1, value: rand_bits(xlen)};
        end
        return op;
    endfunction

    function automatic operand_t woken(operand_t op, logic [preg_len-1:0] tag,
                                       logic [xlen-1:0] value);
        if (!op.ready && op.value[preg_len-1:0] == tag) return '{ready: 1'b1, value: value};
        return op;
    endfunction

    function automatic int free_rob();
        for (int i = 0; i < rob_slots; i++) begin
            if (!sb[i].valid) return i;
        end
        return -1;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int i = 0; i < rob_slots; i++) begin
            if (sb[i].valid) n++;
        end
        return n;
    endfunction

    task automatic wake_scoreboard(logic [preg_len-1:0] tag, logic [xlen-1:0] value);
        for (int i = 0; i < rob_slots; i++) begin
            if (sb[i].valid) begin
                sb[i].base = woken(sb[i].base, tag, value);
                sb[i].src  = woken(sb[i].src, tag, value);
            end
        end
    endtask

    task automatic clear_scoreboard();
        for (int i = 0; i < rob_slots; i++) begin
            sb[i] = '0;
        end
        load_count  = 0;
        store_count = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////
    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at cycle %0d", cycle);
    endtask

    task automatic compare_value(string what, logic [xlen-1:0] expected,
                                 logic [xlen-1:0] actual);
        if (expected !== actual) begin
            $display("error: test %s, %s expected 0x%h actual 0x%h",
                     test_name, what, expected, actual);
            stop_with_failure("output differs from the model");
        end
    endtask

    task automatic watch_output();
        expect_t e;
        if (!mem_valid) return;
        e = sb[mem_req.rob_idx];
        if (!e.valid) stop_with_failure("mem_req carries a rob_idx with no outstanding entry");
        if (!e.base.ready || !e.src.ready) begin
            stop_with_failure("entry issued before its tags were broadcast on the cdb");
        end
        compare_value("is_store", xlen'(e.is_store), xlen'(mem_req.is_store));
        compare_value("addr", e.base.value + e.offset, mem_req.addr);
        compare_value("data", e.is_store ? e.src.value : '0, mem_req.data);
        compare_value("mem_size", xlen'(e.mem_size), xlen'(mem_req.mem_size));
        compare_value("lsq_idx", xlen'(e.lsq_idx), xlen'(mem_req.lsq_idx));
        compare_value("dest_preg", xlen'(e.dest_preg), xlen'(mem_req.dest_preg));
        sb[mem_req.rob_idx].valid = 1'b0;
        if (e.is_store) store_count--;
        else load_count--;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus, one call per falling edge
    ////////////////////////////////////////////////////////////
    task automatic drive_inputs();
        logic [preg_len-1:0] start;
        logic [preg_len-1:0] t;
        logic [rob_len-1:0]  rob;
        logic                fill;
        logic                drain;
        logic                found;
        int                  rob_pick;
        fill  = (cycle >= 1200 && cycle < 1280) || (cycle >= 1700 && cycle < 1800);
        drain = cycle > stim_cycles;
        load_enable  = 1'b0;
        store_enable = 1'b0;
        flush        = 1'b0;
        cdb          = '0;
        if (drain) test_name = "drain";
        else if (fill) test_name = "full";
        else test_name = "ready and wakeup";
        if (cycle == 900 || cycle == 1800) begin
            test_name = "flush";
            flush     = 1'b1;
            clear_scoreboard();   // nothing still in a station may appear
            return;
        end
        // broadcast one waiting tag, every cycle while draining
        if (!fill && (drain || rand_bits(1) != 0)) begin
            start = preg_len'(rand_bits(preg_len));
            found = 1'b0;
            for (int i = 0; i < tag_count; i++) begin
                t = start + preg_len'(i);
                if (!found && tag_waiting[t]) begin
                    found = 1'b1;
                    cdb   = '{valid: 1'b1, tag: t, value: rand_bits(xlen)};
                end
            end
            if (found) begin
                tag_waiting[cdb.tag] = 1'b0;
                wake_scoreboard(cdb.tag, cdb.value);
            end
        end
        rob_pick = free_rob();
        if (!drain && load_count < rs_entries && rob_pick >= 0 &&
            (fill || rand_bits(1) != 0)) begin
            rob         = rob_len'(rob_pick);
            load_enable = 1'b1;
            load_base   = make_operand(fill);
            load_offset = rand_bits(xlen);
            load_info   = '{mem_size: random_size(), rob_idx: rob,
                            lq_idx: lsq_len'(rand_bits(lsq_len)),
                            dest_preg: preg_len'(rand_bits(preg_len))};
            sb[rob]           = '0;
            sb[rob].valid     = 1'b1;
            sb[rob].base      = load_base;
            sb[rob].src.ready = 1'b1;   // loads have no data operand
            sb[rob].offset    = load_offset;
            sb[rob].mem_size  = load_info.mem_size;
            sb[rob].lsq_idx   = load_info.lq_idx;
            sb[rob].dest_preg = load_info.dest_preg;
            load_count++;
        end
        rob_pick = free_rob();
        if (!drain && store_count < rs_entries && rob_pick >= 0 &&
            (fill || rand_bits(1) != 0)) begin
            rob          = rob_len'(rob_pick);
            store_enable = 1'b1;
            store_base   = make_operand(fill);
            store_src    = make_operand(fill);
            store_offset = rand_bits(xlen);
            store_info   = '{mem_size: random_size(), rob_idx: rob,
                             sq_idx: lsq_len'(rand_bits(lsq_len))};
            sb[rob]          = '0;
            sb[rob].valid    = 1'b1;
            sb[rob].is_store = 1'b1;
            sb[rob].base     = store_base;
            sb[rob].src      = store_src;
            sb[rob].offset   = store_offset;
            sb[rob].mem_size = store_info.mem_size;
            sb[rob].lsq_idx  = store_info.sq_idx;
            store_count++;
        end
    endtask

    initial begin
        lfsr_state   = 16'd42584;
        rst          = 1'b1;
        flush        = 1'b0;
        load_enable  = 1'b0;
        load_base    = '0;
        load_offset  = '0;
        load_info    = '0;
        store_enable = 1'b0;
        store_base   = '0;
        store_src    = '0;
        store_offset = '0;
        store_info   = '0;
        cdb          = '0;
        tag_waiting  = '0;
        cycle        = 0;
        quiet_cycles = 0;
        test_name    = "reset";
        clear_scoreboard();
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        while (quiet_cycles < 4 && cycle < cycle_limit) begin
            @(negedge clock);
            cycle++;
            watch_output();
            compare_value("load_full", xlen'(load_count == rs_entries), xlen'(load_full));
            compare_value("store_full", xlen'(store_count == rs_entries), xlen'(store_full));
            if (cycle > stim_cycles && load_count + store_count == 0) quiet_cycles++;
            else quiet_cycles = 0;   // a few idle cycles catch late extras
            drive_inputs();
        end
        if (outstanding() != 0) begin
            stop_with_failure("timeout, dispatched entries never all reached mem_req");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
